// ==== common/lbus_axis_consts.svh ====
`ifndef LBUS_AXIS_CONSTS_SVH
`define LBUS_AXIS_CONSTS_SVH

// segments in one lbus word
`define LBUS_SEGS 4

// one segment
`define SEG_BYTES 16
`define SEG_DATA_W 128

// empty byte count of the eop segment
`define MTY_W 4

// axi stream beat, one per lbus word
`define AXIS_DATA_W 512
`define AXIS_KEEP_W 64

`endif

// ==== common/lbus_axis_pkg.sv ====
`include "lbus_axis_consts.svh"

package lbus_axis_pkg;

	typedef logic [`SEG_DATA_W-1:0] seg_data_t;
	typedef logic [`SEG_BYTES-1:0] seg_keep_t;
	typedef logic [`MTY_W-1:0] mty_t;
	typedef logic [`AXIS_DATA_W-1:0] axis_data_t;
	typedef logic [`AXIS_KEEP_W-1:0] axis_keep_t;

	// one lbus segment as it arrives on the wire
	typedef struct packed {
		seg_data_t data;
		logic ena;
		logic sop;
		logic eop;
		mty_t mty;
		logic err;
	} lbus_seg_t;

	typedef lbus_seg_t [`LBUS_SEGS-1:0] lbus_word_t;

	// decoded segment, data already in axi byte order
	typedef struct packed {
		seg_data_t data;
		seg_keep_t keep;
		logic valid;
		logic sop;
		logic eop;
		logic err;
	} axis_lane_t;

	// tuser carries the packet error on the last beat
	typedef struct packed {
		axis_data_t tdata;
		axis_keep_t tkeep;
		logic tlast;
		logic tuser;
	} axis_beat_t;

	typedef enum logic {
		asm_idle = 1'b0,
		asm_packet = 1'b1
	} asm_state_t;

endpackage

// ==== flist.f ====
+incdir+common
common/lbus_axis_pkg.sv
lbus_rx/lbus_rx_input_stage.sv
lbus_rx/lbus_seg_decoder.sv
lbus_rx/axis_beat_assembler.sv
hw/lbus_to_axis_top.sv
verification/tb_lbus_to_axis.sv

// ==== hw/lbus_to_axis_top.sv ====
`timescale 1ns/1ps
`include "lbus_axis_consts.svh"

module lbus_to_axis_top (
	input logic rx_clk,
	input logic arst_n,
	input lbus_axis_pkg::lbus_word_t lbus_in,
	output lbus_axis_pkg::axis_beat_t axis_out,
	output logic axis_valid
);
	import lbus_axis_pkg::*;

	lbus_word_t seg_q;
	axis_lane_t [`LBUS_SEGS-1:0] lanes;

	// stage 1, input register
	lbus_rx_input_stage u_input_stage (
		.rx_clk (rx_clk),
		.arst_n (arst_n),
		.lbus_in (lbus_in),
		.seg_q (seg_q)
	);

	// stage 2, one decoder per segment
	for (genvar s = 0; s < `LBUS_SEGS; s++) begin : g_dec
		lbus_seg_decoder u_seg_decoder (
			.rx_clk (rx_clk),
			.arst_n (arst_n),
			.seg (seg_q[s]),
			.lane (lanes[s])
		);
	end

	// stage 3, beat assembly and packet tracking
	axis_beat_assembler u_beat_assembler (
		.rx_clk (rx_clk),
		.arst_n (arst_n),
		.lanes (lanes),
		.axis_out (axis_out),
		.axis_valid (axis_valid)
	);

endmodule

// ==== lbus_rx/axis_beat_assembler.sv ====
`timescale 1ns/1ps
`include "lbus_axis_consts.svh"

module axis_beat_assembler (
	input logic rx_clk,
	input logic arst_n,
	input lbus_axis_pkg::axis_lane_t [`LBUS_SEGS-1:0] lanes,
	output lbus_axis_pkg::axis_beat_t axis_out,
	output logic axis_valid
);
	import lbus_axis_pkg::*;

	asm_state_t state_q;
	asm_state_t state_d;

	logic [`LBUS_SEGS-1:0] valid_vec;
	logic [`LBUS_SEGS-1:0] eop_vec;
	logic [`LBUS_SEGS-1:0] err_vec;
	logic any_valid;
	logic word_sop;
	logic word_eop;
	logic emit;

	axis_beat_t beat_d;

	// per lane flags, only counted when the lane holds data
	always_comb begin
		for (int s = 0; s < `LBUS_SEGS; s++) begin
			valid_vec[s] = lanes[s].valid;
			eop_vec[s] = lanes[s].valid & lanes[s].eop;
			err_vec[s] = lanes[s].err;
		end
	end

	assign any_valid = |valid_vec;
	// packets only start in segment 0
	assign word_sop = lanes[0].valid & lanes[0].sop;
	assign word_eop = |eop_vec;

	// lane s fills axi bytes 16s to 16s+15
	always_comb begin
		for (int s = 0; s < `LBUS_SEGS; s++) begin
			beat_d.tdata[`SEG_DATA_W*s +: `SEG_DATA_W] = lanes[s].data;
			beat_d.tkeep[`SEG_BYTES*s +: `SEG_BYTES] = lanes[s].keep;
		end
		beat_d.tlast = word_eop;
		// error of the eop lane only
		beat_d.tuser = |(eop_vec & err_vec);
	end

	always_comb begin
		state_d = state_q;
		emit = 1'b0;
		case (state_q)
			asm_idle: begin
				// words outside a packet are dropped
				if (word_sop) begin
					emit = 1'b1;
					if (!word_eop) begin
						state_d = asm_packet;
					end
				end
			end
			asm_packet: begin
				if (any_valid) begin
					emit = 1'b1;
					if (word_eop) begin
						state_d = asm_idle;
					end
				end
			end
			default: begin
				state_d = asm_idle;
			end
		endcase
	end

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= asm_idle;
			axis_valid <= 1'b0;
		end else begin
			state_q <= state_d;
			axis_valid <= emit;
		end
	end

	// beat contents held between emitted words
	always_ff @(posedge rx_clk) begin
		if (emit) begin
			axis_out <= beat_d;
		end
	end

endmodule

// ==== lbus_rx/lbus_rx_input_stage.sv ====
`timescale 1ns/1ps
`include "lbus_axis_consts.svh"

module lbus_rx_input_stage (
	input logic rx_clk,
	input logic arst_n,
	input lbus_axis_pkg::lbus_word_t lbus_in,
	output lbus_axis_pkg::lbus_word_t seg_q
);
	import lbus_axis_pkg::*;

	for (genvar s = 0; s < `LBUS_SEGS; s++) begin : g_seg
		logic ena_q;
		seg_data_t data_q;
		logic sop_q;
		logic eop_q;
		mty_t mty_q;
		logic err_q;

		// ena qualifies the rest of the segment
		always_ff @(posedge rx_clk or negedge arst_n) begin
			if (!arst_n) begin
				ena_q <= 1'b0;
			end else begin
				ena_q <= lbus_in[s].ena;
			end
		end

		// payload and flags, meaningless without ena
		always_ff @(posedge rx_clk) begin
			data_q <= lbus_in[s].data;
			sop_q <= lbus_in[s].sop;
			eop_q <= lbus_in[s].eop;
			mty_q <= lbus_in[s].mty;
			err_q <= lbus_in[s].err;
		end

		assign seg_q[s] = '{
			data: data_q,
			ena: ena_q,
			sop: sop_q,
			eop: eop_q,
			mty: mty_q,
			err: err_q
		};
	end

endmodule

// ==== lbus_rx/lbus_seg_decoder.sv ====
`timescale 1ns/1ps
`include "lbus_axis_consts.svh"

module lbus_seg_decoder (
	input logic rx_clk,
	input logic arst_n,
	input lbus_axis_pkg::lbus_seg_t seg,
	output lbus_axis_pkg::axis_lane_t lane
);
	import lbus_axis_pkg::*;

	seg_data_t data_swap;
	seg_keep_t keep_d;

	logic valid_q;
	seg_data_t data_q;
	seg_keep_t keep_q;
	logic sop_q;
	logic eop_q;
	logic err_q;

	// lbus byte 0 is the top byte, lane byte 0 the bottom one
	always_comb begin
		for (int k = 0; k < `SEG_BYTES; k++) begin
			data_swap[8*k +: 8] = seg.data[`SEG_DATA_W-8-8*k +: 8];
		end
	end

	// mty counts the unused bytes at the tail of the eop segment
	always_comb begin
		if (!seg.ena) begin
			keep_d = '0;
		end else if (seg.eop) begin
			keep_d = seg_keep_t'('1) >> seg.mty;
		end else begin
			keep_d = '1;
		end
	end

	always_ff @(posedge rx_clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= seg.ena;
		end
	end

	always_ff @(posedge rx_clk) begin
		data_q <= data_swap;
		keep_q <= keep_d;
		sop_q <= seg.sop;
		eop_q <= seg.eop;
		err_q <= seg.err;
	end

	assign lane = '{
		data: data_q,
		keep: keep_q,
		valid: valid_q,
		sop: sop_q,
		eop: eop_q,
		err: err_q
	};

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the lbus to axi stream testbench with verilator

cd "$(dirname "$0")" || exit 1

top=tb_lbus_to_axis
obj_dir=obj_dir
log=sim.log

rm -rf "$obj_dir"
rm -f "$log"

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f \
	--top-module "$top" \
	-Mdir "$obj_dir" \
	-o "V$top"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

"./$obj_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if [ ! -s "$log" ]; then
	echo "simulation log is empty"
	exit 1
fi

# the testbench prints its fail message on any error
if grep -q "CHECKS FAILED" "$log"; then
	echo "testbench reported errors, see $log"
	exit 1
fi

echo "simulation finished without errors, see $log"
exit 0

// ==== verification/tb_lbus_to_axis.sv ====
`timescale 1ns/1ps
`include "lbus_axis_consts.svh"

module tb_lbus_to_axis;
	import lbus_axis_pkg::*;

	logic rx_clk;
	logic arst_n;
	lbus_word_t lbus_in;
	axis_beat_t axis_out;
	logic axis_valid;

	integer seed;
	int cycle;
	int value_errs;
	int missing_errs;
	int unexpected_errs;

	// expected beats, and the monitor cycle at which each one is due
	axis_beat_t exp_q[$];
	int due_q[$];
	axis_beat_t exp_beat;
	logic model_in_pkt;

	lbus_to_axis_top u_lbus_to_axis_top (
		.rx_clk (rx_clk),
		.arst_n (arst_n),
		.lbus_in (lbus_in),
		.axis_out (axis_out),
		.axis_valid (axis_valid)
	);

	always #20 rx_clk = ~rx_clk;

	always @(posedge rx_clk) begin
		cycle <= cycle + 1;
	end

	function automatic int rand_range(input int lo, input int hi);
		return lo + int'({$random(seed)} % (hi - lo + 1));
	endfunction

	function automatic seg_data_t rand_data();
		seg_data_t d;
		for (int i = 0; i < `SEG_DATA_W / 32; i++) begin
			d[32*i +: 32] = $random(seed);
		end
		return d;
	endfunction

	function automatic lbus_seg_t make_seg(input logic ena, input logic sop, input logic eop,
		input mty_t mty, input logic err);
		lbus_seg_t seg;
		seg.data = rand_data();
		seg.ena = ena;
		seg.sop = sop;
		seg.eop = eop;
		seg.mty = mty;
		seg.err = err;
		return seg;
	endfunction

	// reference model, one lbus word in, at most one beat out
	task automatic model_word(input lbus_word_t w);
		axis_beat_t b;
		logic any_ena;
		logic accept;
		int s;
		int k;
		any_ena = 1'b0;
		b.tlast = 1'b0;
		b.tuser = 1'b0;
		for (int i = 0; i < `AXIS_KEEP_W; i++) begin
			s = i / `SEG_BYTES;
			k = i % `SEG_BYTES;
			// lbus byte k sits at the top end of the segment
			b.tdata[8*i +: 8] = w[s].data[`SEG_DATA_W - 1 - 8*k -: 8];
			b.tkeep[i] = w[s].ena && (!w[s].eop || k < `SEG_BYTES - int'(w[s].mty));
		end
		for (int i = 0; i < `LBUS_SEGS; i++) begin
			any_ena = any_ena | w[i].ena;
			if (w[i].ena && w[i].eop) begin
				b.tlast = 1'b1;
				b.tuser = w[i].err;
			end
		end
		accept = model_in_pkt ? any_ena : (w[0].ena && w[0].sop);
		if (accept) begin
			exp_q.push_back(b);
			// input stage, decoder and assembler registers
			due_q.push_back(cycle + 4);
			model_in_pkt = !b.tlast;
		end
	endtask

	task automatic send_word(input lbus_word_t w);
		@(posedge rx_clk);
		lbus_in <= w;
		model_word(w);
	endtask

	task automatic send_idle();
		lbus_word_t w;
		for (int s = 0; s < `LBUS_SEGS; s++) begin
			w[s] = make_seg(1'b0, 1'b0, 1'b0, '0, 1'b0);
		end
		send_word(w);
	endtask

	// word without sop, only sent between packets
	task automatic send_orphan(input int segs);
		lbus_word_t w;
		for (int s = 0; s < `LBUS_SEGS; s++) begin
			w[s] = make_seg(s < segs, 1'b0, s == segs - 1, mty_t'($random(seed)), 1'b0);
		end
		send_word(w);
	endtask

	task automatic send_packet(input int nwords, input int last_segs, input mty_t mty,
		input logic err_eop, input logic err_mid, input logic gaps);
		lbus_word_t w;
		logic is_last;
		logic is_eop;
		for (int n = 0; n < nwords; n++) begin
			is_last = (n == nwords - 1);
			for (int s = 0; s < `LBUS_SEGS; s++) begin
				is_eop = is_last && (s == last_segs - 1);
				w[s] = make_seg(!is_last || s < last_segs, n == 0 && s == 0, is_eop,
					is_eop ? mty : mty_t'($random(seed)),
					is_eop ? err_eop : (err_mid && s == 0));
			end
			send_word(w);
			if (gaps && !is_last) begin
				send_idle();
			end
		end
	endtask

	// idle words until every expected beat has been seen
	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		while (due_q.size() != 0 && n < limit) begin
			send_idle();
			n++;
		end
		assert (due_q.size() == 0) else begin
			$display("ERROR: timeout with %0d expected beats still pending", due_q.size());
			missing_errs++;
		end
	endtask

	task automatic compare_beat(input axis_beat_t got, input axis_beat_t exp);
		assert (got.tdata == exp.tdata) else begin
			$display("FAIL axis_out.tdata got %h expected %h", got.tdata, exp.tdata);
			value_errs++;
		end
		assert (got.tkeep == exp.tkeep) else begin
			$display("FAIL axis_out.tkeep got %h expected %h", got.tkeep, exp.tkeep);
			value_errs++;
		end
		assert (got.tlast == exp.tlast) else begin
			$display("FAIL axis_out.tlast got %h expected %h", got.tlast, exp.tlast);
			value_errs++;
		end
		assert (got.tuser == exp.tuser) else begin
			$display("FAIL axis_out.tuser got %h expected %h", got.tuser, exp.tuser);
			value_errs++;
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge rx_clk) begin
		if (!arst_n) begin
			assert (!axis_valid) else begin
				$display("ERROR: axis_valid high during reset at cycle %0d", cycle);
				unexpected_errs++;
			end
		end
		while (due_q.size() != 0 && due_q[0] < cycle) begin
			$display("ERROR: beat due at cycle %0d never arrived", due_q[0]);
			missing_errs++;
			void'(exp_q.pop_front());
			void'(due_q.pop_front());
		end
		if (axis_valid) begin
			assert (due_q.size() != 0 && due_q[0] == cycle) else begin
				$display("ERROR: beat at cycle %0d was not expected", cycle);
				unexpected_errs++;
			end
			if (due_q.size() != 0 && due_q[0] == cycle) begin
				exp_beat = exp_q.pop_front();
				void'(due_q.pop_front());
				compare_beat(axis_out, exp_beat);
			end
		end
	end

	initial begin
		lbus_word_t rst_word;
		seed = 50325;
		cycle = 0;
		value_errs = 0;
		missing_errs = 0;
		unexpected_errs = 0;
		model_in_pkt = 1'b0;
		rx_clk = 1'b0;
		arst_n = 1'b0;
		lbus_in = '0;

		// full sop words while in reset must not come out
		repeat (7) begin
			@(posedge rx_clk);
			for (int s = 0; s < `LBUS_SEGS; s++) begin
				rst_word[s] = make_seg(1'b1, s == 0, s == `LBUS_SEGS - 1, '0, 1'b0);
			end
			lbus_in <= rst_word;
		end
		@(posedge rx_clk);
		arst_n <= 1'b1;
		lbus_in <= '0;

		// nothing may come out before the first sop
		repeat (3) send_idle();
		send_orphan(4);
		send_orphan(2);
		repeat (2) send_idle();

		// single word, all segments, no empty bytes
		send_packet(1, 4, '0, 1'b0, 1'b0, 1'b0);
		wait_drain(20);

		// multi word with random eop segment and mty
		for (int i = 0; i < 6; i++) begin
			send_packet(rand_range(2, 5), rand_range(1, 4), mty_t'(rand_range(0, 15)),
				1'b0, 1'b0, 1'b0);
		end
		wait_drain(20);

		// orphans and empty cycles around and inside packets
		send_orphan(3);
		send_idle();
		send_packet(3, 2, mty_t'(7), 1'b0, 1'b0, 1'b1);
		send_orphan(4);
		send_orphan(1);
		send_idle();
		send_packet(2, 4, mty_t'(15), 1'b0, 1'b0, 1'b1);
		send_orphan(2);
		wait_drain(20);

		// tuser only from the eop segment
		send_packet(3, rand_range(1, 4), mty_t'(rand_range(0, 15)), 1'b1, 1'b0, 1'b0);
		send_packet(2, 3, mty_t'(5), 1'b0, 1'b1, 1'b0);
		send_packet(1, 1, mty_t'(2), 1'b1, 1'b0, 1'b0);
		send_packet(1, 3, '0, 1'b0, 1'b1, 1'b0);
		send_packet(2, 2, mty_t'(9), 1'b1, 1'b1, 1'b0);
		wait_drain(20);

		// back to back random packets
		for (int i = 0; i < 50; i++) begin
			send_packet(rand_range(1, 4), rand_range(1, 4), mty_t'(rand_range(0, 15)),
				logic'(rand_range(0, 1)), logic'(rand_range(0, 1)), 1'b0);
		end
		wait_drain(20);
		repeat (6) send_idle();

		assert (exp_q.size() == 0) else begin
			$display("ERROR: %0d expected beats left in the queue", exp_q.size());
			missing_errs++;
		end

		$display("errors: value %0d, missing %0d, unexpected %0d",
			value_errs, missing_errs, unexpected_errs);
		if (value_errs + missing_errs + unexpected_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule
